// File: testbench/axi_order_cases.txt
# kind port id addr len resp last code idle, all hex; code and idle are the expected outputs
# kind 0 mst AW, 1 mst AR, 2 mst B, 3 mst R, 4 slv AW, 5 slv AR, 6 slv B, 7 slv R
# routing by address, then a changed resp code
0 0 1 00002000 03 0 1 0 0
4 2 7 00002000 03 0 1 0 0
6 2 0 00000000 00 2 1 0 0
2 0 1 00000000 00 0 1 5 1
4 1 0 00001000 00 0 1 2 1
# request compare ignores ID, beats without last are skipped
1 0 3 00003040 07 0 1 0 0
5 3 9 00003040 07 0 1 0 0
7 3 0 00000000 00 0 0 0 0
7 3 0 00000000 00 0 1 0 0
3 0 3 00000000 00 0 0 0 0
3 0 3 00000000 00 0 1 0 1
1 0 2 00000010 01 0 1 0 0
5 0 2 00000010 02 0 1 3 0
3 0 2 00000000 00 0 1 4 1
# same ID to ports 0 and 3
0 0 5 00000100 00 0 1 0 0
0 0 5 00003100 01 0 1 0 0
4 3 0 00003100 01 0 1 0 0
4 0 0 00000100 00 0 1 0 0
6 3 e 00000000 00 0 1 0 0
6 0 2 00000000 00 0 1 0 0
2 0 5 00000000 00 0 1 0 0
2 0 5 00000000 00 0 1 0 1
# swapped master order on one port
0 0 6 00001200 02 0 1 0 0
0 0 7 00001300 00 0 1 0 0
4 1 0 00001200 02 0 1 0 0
4 1 0 00001300 00 0 1 0 0
6 1 0 00000000 00 0 1 0 0
6 1 0 00000000 00 0 1 0 0
2 0 7 00000000 00 0 1 5 0
2 0 6 00000000 00 0 1 5 1
# decode error and orphan response
1 0 1 00008000 00 0 1 1 1
3 0 1 00000000 00 0 1 4 1

// File: axi_order_monitor.f
src/axi_mon_pkg.sv
src/sync_fifo.sv
src/req_tracker.sv
src/rsp_tracker.sv
src/monitor_status.sv
src/axi_order_monitor.sv
testbench/order_checker.sv
testbench/axi_order_monitor_sva.sv
testbench/tb_axi_order_monitor.sv

// File: Makefile
# Verilator flow for the AXI ordering monitor

VERILATOR ?= verilator
TOP       ?= tb_axi_order_monitor
FILELIST  ?= axi_order_monitor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_axi_order_monitor.sv
`timescale 1ns/1ps

module tb_axi_order_monitor import axi_mon_pkg::*; ();

  localparam string CASE_FILE    = "testbench/axi_order_cases.txt";
  localparam int    DRIVE_DELAY  = 1;
  localparam int    IDLE_TIMEOUT = 50;
  localparam int    DONE_TIMEOUT = 20;

  logic clk;
  logic reset;

  ax_chan_t                  mst_aw;
  ax_chan_t                  mst_ar;
  ax_chan_t [NUM_PORTS-1:0]  slv_aw;
  ax_chan_t [NUM_PORTS-1:0]  slv_ar;
  rsp_chan_t [NUM_PORTS-1:0] slv_b;
  rsp_chan_t [NUM_PORTS-1:0] slv_r;
  rsp_chan_t                 mst_b;
  rsp_chan_t                 mst_r;

  logic       err_valid;
  err_info_t  err_info;
  err_count_t err_count;
  logic       idle;

  // expectations handed to the checker
  logic      exp_valid;
  err_code_e exp_code;
  path_e     exp_path;
  logic      idle_chk;
  logic      exp_idle;
  logic      end_chk;
  logic      check_done;
  int        check_errors;
  int        tb_errors;
  int        num_cases;

  axi_order_monitor axi_order_monitor_inst (
    .clk_i       (clk),
    .reset_i     (reset),
    .mst_aw_i    (mst_aw),
    .mst_ar_i    (mst_ar),
    .slv_aw_i    (slv_aw),
    .slv_ar_i    (slv_ar),
    .slv_b_i     (slv_b),
    .slv_r_i     (slv_r),
    .mst_b_i     (mst_b),
    .mst_r_i     (mst_r),
    .err_valid_o (err_valid),
    .err_info_o  (err_info),
    .err_count_o (err_count),
    .idle_o      (idle)
  );

  order_checker order_checker_inst (
    .clk_i         (clk),
    .reset_i       (reset),
    .err_valid_i   (err_valid),
    .err_info_i    (err_info),
    .err_count_i   (err_count),
    .idle_i        (idle),
    .exp_valid_i   (exp_valid),
    .exp_code_i    (exp_code),
    .exp_path_i    (exp_path),
    .idle_chk_i    (idle_chk),
    .exp_idle_i    (exp_idle),
    .end_chk_i     (end_chk),
    .done_o        (check_done),
    .error_count_o (check_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic ax_chan_t make_req(axi_id_t id, axi_addr_t addr, axi_len_t len);
    ax_chan_t ch;
    ch.valid     = 1'b1;
    ch.ready     = 1'b1;
    ch.beat.id   = id;
    ch.beat.addr = addr;
    ch.beat.len  = len;
    return ch;
  endfunction

  function automatic rsp_chan_t make_rsp(axi_id_t id, axi_resp_t resp, logic last);
    rsp_chan_t ch;
    ch.valid     = 1'b1;
    ch.ready     = 1'b1;
    ch.beat.id   = id;
    ch.beat.resp = resp;
    ch.beat.last = last;
    return ch;
  endfunction

  task automatic clear_inputs();
    mst_aw = '0;
    mst_ar = '0;
    slv_aw = '0;
    slv_ar = '0;
    slv_b  = '0;
    slv_r  = '0;
    mst_b  = '0;
    mst_r  = '0;
  endtask

  // B beats always carry last
  task automatic drive_event(input logic [3:0] kind, input port_idx_t port, input axi_id_t id,
                             input axi_addr_t addr, input axi_len_t len, input axi_resp_t resp,
                             input logic last);
    case (kind)
      4'h0: mst_aw = make_req(id, addr, len);
      4'h1: mst_ar = make_req(id, addr, len);
      4'h2: mst_b = make_rsp(id, resp, 1'b1);
      4'h3: mst_r = make_rsp(id, resp, last);
      4'h4: slv_aw[port] = make_req(id, addr, len);
      4'h5: slv_ar[port] = make_req(id, addr, len);
      4'h6: slv_b[port] = make_rsp(id, resp, 1'b1);
      4'h7: slv_r[port] = make_rsp(id, resp, last);
      default: begin
        $display("Unknown event kind %0h in the case file", kind);
        tb_errors++;
      end
    endcase
  endtask

  // one drive cycle, then three quiet cycles; idle is checked in the last one
  task automatic run_case(input logic [31:0] f_kind, input logic [31:0] f_port,
                          input logic [31:0] f_id, input logic [31:0] f_addr,
                          input logic [31:0] f_len, input logic [31:0] f_resp,
                          input logic [31:0] f_last, input logic [31:0] f_code,
                          input logic [31:0] f_idle);
    drive_event(f_kind[3:0], f_port[PORT_IDX_WIDTH-1:0], f_id[ID_WIDTH-1:0], f_addr,
                f_len[LEN_WIDTH-1:0], f_resp[RESP_WIDTH-1:0], f_last[0]);
    @(posedge clk);
    #DRIVE_DELAY;
    clear_inputs();
    idle_chk = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    exp_code  = err_code_e'(f_code[2:0]);
    // odd kinds belong to the read path
    exp_path  = path_e'(f_kind[0]);
    exp_valid = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    exp_valid = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    exp_idle = f_idle[0];
    idle_chk = 1'b1;
  endtask

  task automatic wait_for_idle();
    int cycles;
    cycles = 0;
    while (!idle && cycles < IDLE_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    if (!idle) begin
      $display("Timeout: monitor did not return to idle after the last case");
      tb_errors++;
    end
  endtask

  task automatic wait_for_checker();
    int cycles;
    cycles = 0;
    while (!check_done && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
    end
    if (!check_done) begin
      $display("Timeout: checker did not finish its closing checks");
      tb_errors++;
    end
  endtask

  initial begin
    int          fd;
    int          rc;
    int          fields;
    string       line;
    logic [31:0] f_kind;
    logic [31:0] f_port;
    logic [31:0] f_id;
    logic [31:0] f_addr;
    logic [31:0] f_len;
    logic [31:0] f_resp;
    logic [31:0] f_last;
    logic [31:0] f_code;
    logic [31:0] f_idle;

    reset     = 1'b1;
    clear_inputs();
    exp_valid = 1'b0;
    exp_code  = ERR_NONE;
    exp_path  = PATH_WRITE;
    idle_chk  = 1'b0;
    exp_idle  = 1'b1;
    end_chk   = 1'b0;
    tb_errors = 0;
    num_cases = 0;

    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the case file %s", CASE_FILE);
      tb_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc   = $fgets(line, fd);
        // header and blank lines yield no fields
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_kind, f_port, f_id, f_addr,
                         f_len, f_resp, f_last, f_code, f_idle);
        if (rc > 0 && fields == 9) begin
          run_case(f_kind, f_port, f_id, f_addr, f_len, f_resp, f_last, f_code, f_idle);
          num_cases++;
        end
      end
      $fclose(fd);
    end
    if (num_cases == 0) begin
      $display("No cases were read from %s", CASE_FILE);
      tb_errors++;
    end

    @(posedge clk);
    #DRIVE_DELAY;
    idle_chk = 1'b0;
    wait_for_idle();
    end_chk = 1'b1;
    wait_for_checker();

    $display("cases %0d, check errors %0d, other errors %0d", num_cases, check_errors,
             tb_errors);
    if (check_errors == 0 && tb_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: testbench/axi_order_monitor_sva.sv
`timescale 1ns/1ps

module axi_order_monitor_sva import axi_mon_pkg::*; (
  input logic       clk_i,
  input logic       reset_i,
  input logic       err_valid_i,
  input err_info_t  err_info_i,
  input err_count_t err_count_i,
  input logic       idle_i
);

  // a reported error always carries a real code
  a_code_set: assert property (@(posedge clk_i) disable iff (reset_i)
    err_valid_i |-> (err_info_i.code != ERR_NONE))
    else $error("err_valid_o high with code ERR_NONE");

  // saturating counter, never goes back
  a_count_monotonic: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> (err_count_i >= $past(err_count_i)))
    else $error("err_count_o decreased outside reset");

  a_idle_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> idle_i)
    else $error("idle_o low in the first cycle after reset");

endmodule

bind axi_order_monitor axi_order_monitor_sva axi_order_monitor_sva_inst (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .err_valid_i (err_valid_o),
  .err_info_i  (err_info_o),
  .err_count_i (err_count_o),
  .idle_i      (idle_o)
);

// File: testbench/order_checker.sv
`timescale 1ns/1ps

module order_checker import axi_mon_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       err_valid_i,
  input  err_info_t  err_info_i,
  input  err_count_t err_count_i,
  input  logic       idle_i,
  input  logic       exp_valid_i,
  input  err_code_e  exp_code_i,
  input  path_e      exp_path_i,
  input  logic       idle_chk_i,
  input  logic       exp_idle_i,
  input  logic       end_chk_i,
  output logic       done_o,
  output int         error_count_o
);

  // expected errors seen so far
  int tally;

  // sample mid cycle where the outputs are stable
  always @(negedge clk_i) begin
    if (reset_i) begin
      tally         = 0;
      error_count_o = 0;
      done_o        = 1'b0;
    end else begin
      if (exp_valid_i) begin
        if (exp_code_i != ERR_NONE) begin
          tally++;
        end
        if ((err_valid_i !== (exp_code_i != ERR_NONE)) ||
            (err_valid_i && (err_info_i.code !== exp_code_i)) ||
            (err_valid_i && (err_info_i.path !== exp_path_i))) begin
          $display("Error %0t: pulse %b code %s path %s, expected code %s path %s", $time,
                   err_valid_i, err_info_i.code.name(), err_info_i.path.name(),
                   exp_code_i.name(), exp_path_i.name());
          error_count_o++;
        end
      end else if (err_valid_i !== 1'b0) begin
        $display("Error %0t: error pulse with code %s where none was expected", $time,
                 err_info_i.code.name());
        error_count_o++;
      end
      if (idle_chk_i && (idle_i !== exp_idle_i)) begin
        $display("Error %0t: idle_o is %b, expected %b", $time, idle_i, exp_idle_i);
        error_count_o++;
      end
      if (end_chk_i && !done_o) begin
        if (err_count_i !== err_count_t'(tally)) begin
          $display("Error %0t: err_count_o is %0d, expected %0d", $time, err_count_i, tally);
          error_count_o++;
        end
        if (idle_i !== 1'b1) begin
          $display("Error %0t: idle_o is low at the end of the run", $time);
          error_count_o++;
        end
        done_o = 1'b1;
      end
    end
  end

endmodule

// File: src/axi_order_monitor.sv
`timescale 1ns/1ps

module axi_order_monitor import axi_mon_pkg::*; (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  ax_chan_t                  mst_aw_i,
  input  ax_chan_t                  mst_ar_i,
  input  ax_chan_t [NUM_PORTS-1:0]  slv_aw_i,
  input  ax_chan_t [NUM_PORTS-1:0]  slv_ar_i,
  input  rsp_chan_t [NUM_PORTS-1:0] slv_b_i,
  input  rsp_chan_t [NUM_PORTS-1:0] slv_r_i,
  input  rsp_chan_t                 mst_b_i,
  input  rsp_chan_t                 mst_r_i,
  output logic                      err_valid_o,
  output err_info_t                 err_info_o,
  output err_count_t                err_count_o,
  output logic                      idle_o
);

  // write path strobes
  logic      wr_issue_valid;
  port_idx_t wr_issue_port;
  axi_id_t   wr_issue_id;
  logic      wr_accept_valid;
  port_idx_t wr_accept_port;
  axi_id_t   wr_accept_id;

  // read path strobes
  logic      rd_issue_valid;
  port_idx_t rd_issue_port;
  axi_id_t   rd_issue_id;
  logic      rd_accept_valid;
  port_idx_t rd_accept_port;
  axi_id_t   rd_accept_id;

  // status sources: wr req, wr rsp, rd req, rd rsp
  logic [3:0]      src_err_valid;
  err_info_t [3:0] src_err_info;
  logic [3:0]      src_idle;

  req_tracker #(.PATH(PATH_WRITE)) wr_req_tracker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .mst_ax_i       (mst_aw_i),
    .slv_ax_i       (slv_aw_i),
    .issue_valid_o  (wr_issue_valid),
    .issue_port_o   (wr_issue_port),
    .issue_id_o     (wr_issue_id),
    .accept_valid_o (wr_accept_valid),
    .accept_port_o  (wr_accept_port),
    .accept_id_o    (wr_accept_id),
    .err_valid_o    (src_err_valid[0]),
    .err_info_o     (src_err_info[0]),
    .idle_o         (src_idle[0])
  );

  rsp_tracker #(.PATH(PATH_WRITE)) wr_rsp_tracker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_valid_i  (wr_issue_valid),
    .issue_port_i   (wr_issue_port),
    .issue_id_i     (wr_issue_id),
    .accept_valid_i (wr_accept_valid),
    .accept_port_i  (wr_accept_port),
    .accept_id_i    (wr_accept_id),
    .slv_rsp_i      (slv_b_i),
    .mst_rsp_i      (mst_b_i),
    .err_valid_o    (src_err_valid[1]),
    .err_info_o     (src_err_info[1]),
    .idle_o         (src_idle[1])
  );

  req_tracker #(.PATH(PATH_READ)) rd_req_tracker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .mst_ax_i       (mst_ar_i),
    .slv_ax_i       (slv_ar_i),
    .issue_valid_o  (rd_issue_valid),
    .issue_port_o   (rd_issue_port),
    .issue_id_o     (rd_issue_id),
    .accept_valid_o (rd_accept_valid),
    .accept_port_o  (rd_accept_port),
    .accept_id_o    (rd_accept_id),
    .err_valid_o    (src_err_valid[2]),
    .err_info_o     (src_err_info[2]),
    .idle_o         (src_idle[2])
  );

  rsp_tracker #(.PATH(PATH_READ)) rd_rsp_tracker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_valid_i  (rd_issue_valid),
    .issue_port_i   (rd_issue_port),
    .issue_id_i     (rd_issue_id),
    .accept_valid_i (rd_accept_valid),
    .accept_port_i  (rd_accept_port),
    .accept_id_i    (rd_accept_id),
    .slv_rsp_i      (slv_r_i),
    .mst_rsp_i      (mst_r_i),
    .err_valid_o    (src_err_valid[3]),
    .err_info_o     (src_err_info[3]),
    .idle_o         (src_idle[3])
  );

  monitor_status monitor_status_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .src_err_valid_i (src_err_valid),
    .src_err_info_i  (src_err_info),
    .src_idle_i      (src_idle),
    .err_valid_o     (err_valid_o),
    .err_info_o      (err_info_o),
    .err_count_o     (err_count_o),
    .idle_o          (idle_o)
  );

endmodule

// File: src/monitor_status.sv
`timescale 1ns/1ps

module monitor_status import axi_mon_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic [3:0]      src_err_valid_i,
  input  err_info_t [3:0] src_err_info_i,
  input  logic [3:0]      src_idle_i,
  output logic            err_valid_o,
  output err_info_t       err_info_o,
  output err_count_t      err_count_o,
  output logic            idle_o
);

  err_info_t                sel_info;
  logic [2:0]               num_err;
  logic [ERR_COUNT_WIDTH:0] count_sum;

  // source 0 has the highest priority, so scan it last
  always_comb begin
    sel_info = '{code: ERR_NONE, path: PATH_WRITE, port: '0};
    num_err  = '0;
    for (int i = 3; i >= 0; i--) begin
      if (src_err_valid_i[i]) begin
        sel_info = src_err_info_i[i];
        num_err  = num_err + 3'd1;
      end
    end
  end

  // extra bit catches the wrap for saturation
  assign count_sum = {1'b0, err_count_o} + (ERR_COUNT_WIDTH + 1)'(num_err);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_valid_o <= 1'b0;
      err_info_o  <= '{code: ERR_NONE, path: PATH_WRITE, port: '0};
      err_count_o <= '0;
      idle_o      <= 1'b1;
    end else begin
      err_valid_o <= |src_err_valid_i;
      err_info_o  <= sel_info;
      if (count_sum[ERR_COUNT_WIDTH]) begin
        err_count_o <= '1;
      end else begin
        err_count_o <= count_sum[ERR_COUNT_WIDTH-1:0];
      end
      idle_o <= &src_idle_i;
    end
  end

endmodule

// File: src/rsp_tracker.sv
`timescale 1ns/1ps

module rsp_tracker import axi_mon_pkg::*; #(
  parameter path_e PATH = PATH_WRITE
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      issue_valid_i,
  input  port_idx_t                 issue_port_i,
  input  axi_id_t                   issue_id_i,
  input  logic                      accept_valid_i,
  input  port_idx_t                 accept_port_i,
  input  axi_id_t                   accept_id_i,
  input  rsp_chan_t [NUM_PORTS-1:0] slv_rsp_i,
  input  rsp_chan_t                 mst_rsp_i,
  output logic                      err_valid_o,
  output err_info_t                 err_info_o,
  output logic                      idle_o
);

  // per slave port
  logic [NUM_PORTS-1:0]      slv_fire;
  logic [NUM_PORTS-1:0]      id_push;
  logic [NUM_PORTS-1:0]      id_empty;
  logic [NUM_PORTS-1:0]      id_full;
  axi_id_t [NUM_PORTS-1:0]   id_head;
  logic [NUM_PORTS-1:0]      rsp_push;
  logic [NUM_PORTS-1:0]      rsp_pop;
  logic [NUM_PORTS-1:0]      rsp_empty;
  logic [NUM_PORTS-1:0]      rsp_full;
  rsp_beat_t [NUM_PORTS-1:0] rsp_data;
  rsp_beat_t [NUM_PORTS-1:0] rsp_head;

  // per ID, the ports in issue order
  logic [NUM_IDS-1:0]      ord_push;
  logic [NUM_IDS-1:0]      ord_pop;
  logic [NUM_IDS-1:0]      ord_empty;
  logic [NUM_IDS-1:0]      ord_full;
  port_idx_t [NUM_IDS-1:0] ord_head;

  logic      mst_fire;
  axi_id_t   mst_id;
  port_idx_t mst_port;
  rsp_beat_t exp_rsp;
  logic      err_valid_d;
  err_info_t err_info_d;

  // only the closing beat of a burst counts
  assign mst_fire = mst_rsp_i.valid && mst_rsp_i.ready && mst_rsp_i.beat.last;
  assign mst_id   = mst_rsp_i.beat.id;
  assign mst_port = ord_head[mst_id];
  assign exp_rsp  = rsp_head[mst_port];

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign slv_fire[i] = slv_rsp_i[i].valid && slv_rsp_i[i].ready && slv_rsp_i[i].beat.last;
    assign id_push[i]  = accept_valid_i && (accept_port_i == PORT_IDX_WIDTH'(i));
    assign rsp_push[i] = slv_fire[i] && !id_empty[i];
    assign rsp_pop[i]  = mst_fire && !ord_empty[mst_id] && (mst_port == PORT_IDX_WIDTH'(i));
    // restore the master ID from the port's accept order
    assign rsp_data[i] = '{id: id_head[i], resp: slv_rsp_i[i].beat.resp,
                           last: slv_rsp_i[i].beat.last};

    sync_fifo #(.WIDTH(ID_WIDTH), .DEPTH(FIFO_DEPTH)) id_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (id_push[i]),
      .data_i  (accept_id_i),
      .pop_i   (slv_fire[i]),
      .data_o  (id_head[i]),
      .empty_o (id_empty[i]),
      .full_o  (id_full[i])
    );

    sync_fifo #(.WIDTH($bits(rsp_beat_t)), .DEPTH(FIFO_DEPTH)) rsp_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (rsp_push[i]),
      .data_i  (rsp_data[i]),
      .pop_i   (rsp_pop[i]),
      .data_o  (rsp_head[i]),
      .empty_o (rsp_empty[i]),
      .full_o  (rsp_full[i])
    );
  end

  for (genvar j = 0; j < NUM_IDS; j++) begin : gen_id
    assign ord_push[j] = issue_valid_i && (issue_id_i == ID_WIDTH'(j));
    assign ord_pop[j]  = mst_fire && (mst_id == ID_WIDTH'(j));

    sync_fifo #(.WIDTH(PORT_IDX_WIDTH), .DEPTH(FIFO_DEPTH)) ord_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (ord_push[j]),
      .data_i  (issue_port_i),
      .pop_i   (ord_pop[j]),
      .data_o  (ord_head[j]),
      .empty_o (ord_empty[j]),
      .full_o  (ord_full[j])
    );
  end

  // lowest priority first, later checks overwrite
  always_comb begin
    err_valid_d = 1'b0;
    err_info_d  = '{code: ERR_NONE, path: PATH, port: '0};
    if (mst_fire) begin
      if (ord_empty[mst_id]) begin
        err_valid_d     = 1'b1;
        err_info_d.code = ERR_RSP_UNEXPECTED;
      end else if (rsp_empty[mst_port]) begin
        err_valid_d     = 1'b1;
        err_info_d.code = ERR_RSP_UNEXPECTED;
        err_info_d.port = mst_port;
      end else if ((exp_rsp.id != mst_id) || (exp_rsp.resp != mst_rsp_i.beat.resp)) begin
        err_valid_d     = 1'b1;
        err_info_d.code = ERR_RSP_MISMATCH;
        err_info_d.port = mst_port;
      end
    end
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      if (slv_fire[i] && (id_empty[i] || rsp_full[i])) begin
        err_valid_d     = 1'b1;
        err_info_d.code = id_empty[i] ? ERR_RSP_UNEXPECTED : ERR_OVERFLOW;
        err_info_d.port = PORT_IDX_WIDTH'(i);
      end
    end
    if (accept_valid_i && id_full[accept_port_i]) begin
      err_valid_d     = 1'b1;
      err_info_d.code = ERR_OVERFLOW;
      err_info_d.port = accept_port_i;
    end
    if (issue_valid_i && ord_full[issue_id_i]) begin
      err_valid_d     = 1'b1;
      err_info_d.code = ERR_OVERFLOW;
      err_info_d.port = issue_port_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_valid_o <= 1'b0;
      idle_o      <= 1'b1;
    end else begin
      err_valid_o <= err_valid_d;
      idle_o      <= &{id_empty, rsp_empty, ord_empty};
    end
  end

  always_ff @(posedge clk_i) begin
    err_info_o <= err_info_d;
  end

endmodule

// File: src/req_tracker.sv
`timescale 1ns/1ps

module req_tracker import axi_mon_pkg::*; #(
  parameter path_e PATH = PATH_WRITE
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  ax_chan_t                 mst_ax_i,
  input  ax_chan_t [NUM_PORTS-1:0] slv_ax_i,
  output logic                     issue_valid_o,
  output port_idx_t                issue_port_o,
  output axi_id_t                  issue_id_o,
  output logic                     accept_valid_o,
  output port_idx_t                accept_port_o,
  output axi_id_t                  accept_id_o,
  output logic                     err_valid_o,
  output err_info_t                err_info_o,
  output logic                     idle_o
);

  logic                     mst_fire;
  logic                     mst_in_range;
  port_idx_t                mst_port;
  logic [NUM_PORTS-1:0]     slv_fire;
  logic [NUM_PORTS-1:0]     push;
  logic [NUM_PORTS-1:0]     empty;
  logic [NUM_PORTS-1:0]     full;
  ax_beat_t [NUM_PORTS-1:0] head;

  logic      issue_valid_d;
  logic      accept_valid_d;
  port_idx_t accept_port_d;
  axi_id_t   accept_id_d;
  logic      err_valid_d;
  err_info_t err_info_d;

  assign mst_fire     = mst_ax_i.valid && mst_ax_i.ready;
  assign mst_port     = mst_ax_i.beat.addr[REGION_LSB +: PORT_IDX_WIDTH];
  assign mst_in_range = (mst_ax_i.beat.addr < DECODE_LIMIT);

  // one expectation FIFO per slave port, in master issue order
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_port
    assign slv_fire[i] = slv_ax_i[i].valid && slv_ax_i[i].ready;
    assign push[i]     = mst_fire && mst_in_range && (mst_port == PORT_IDX_WIDTH'(i));

    sync_fifo #(
      .WIDTH ($bits(ax_beat_t)),
      .DEPTH (FIFO_DEPTH)
    ) exp_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (push[i]),
      .data_i  (mst_ax_i.beat),
      .pop_i   (slv_fire[i]),
      .data_o  (head[i]),
      .empty_o (empty[i]),
      .full_o  (full[i])
    );
  end

  always_comb begin
    issue_valid_d  = 1'b0;
    accept_valid_d = 1'b0;
    accept_port_d  = '0;
    accept_id_d    = '0;
    err_valid_d    = 1'b0;
    err_info_d     = '{code: ERR_NONE, path: PATH, port: '0};
    // walk ports downwards so the lowest port is reported last
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      if (slv_fire[i]) begin
        if (empty[i]) begin
          err_valid_d     = 1'b1;
          err_info_d.code = ERR_REQ_UNEXPECTED;
          err_info_d.port = PORT_IDX_WIDTH'(i);
        end else if ((head[i].addr != slv_ax_i[i].beat.addr) ||
                     (head[i].len != slv_ax_i[i].beat.len)) begin
          err_valid_d     = 1'b1;
          err_info_d.code = ERR_REQ_MISMATCH;
          err_info_d.port = PORT_IDX_WIDTH'(i);
        end else begin
          // slave side ID is rewritten by the interconnect, keep ours
          accept_valid_d = 1'b1;
          accept_port_d  = PORT_IDX_WIDTH'(i);
          accept_id_d    = head[i].id;
        end
      end
    end
    // master side errors win over slave side ones
    if (mst_fire) begin
      if (!mst_in_range) begin
        err_valid_d     = 1'b1;
        err_info_d.code = ERR_DECODE;
        err_info_d.port = mst_port;
      end else if (full[mst_port]) begin
        err_valid_d     = 1'b1;
        err_info_d.code = ERR_OVERFLOW;
        err_info_d.port = mst_port;
      end else begin
        issue_valid_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      issue_valid_o  <= 1'b0;
      accept_valid_o <= 1'b0;
      err_valid_o    <= 1'b0;
      idle_o         <= 1'b1;
    end else begin
      issue_valid_o  <= issue_valid_d;
      accept_valid_o <= accept_valid_d;
      err_valid_o    <= err_valid_d;
      idle_o         <= &empty;
    end
  end

  always_ff @(posedge clk_i) begin
    issue_port_o  <= mst_port;
    issue_id_o    <= mst_ax_i.beat.id;
    accept_port_o <= accept_port_d;
    accept_id_o   <= accept_id_d;
    err_info_o    <= err_info_d;
  end

endmodule

// File: src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  // a single entry still needs one pointer bit
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]     mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;
  logic                 do_push;
  logic                 do_pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_WIDTH'(DEPTH));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap at DEPTH, not at a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

endmodule

// File: src/axi_mon_pkg.sv
package axi_mon_pkg;

  // interconnect geometry
  localparam int NUM_PORTS      = 4;
  localparam int PORT_IDX_WIDTH = 2;
  localparam int ID_WIDTH       = 4;
  localparam int NUM_IDS        = 16;
  localparam int ADDR_WIDTH     = 32;
  localparam int LEN_WIDTH      = 8;
  localparam int RESP_WIDTH     = 2;

  // expectation storage and status
  localparam int FIFO_DEPTH      = 8;
  localparam int ERR_COUNT_WIDTH = 16;

  // address bits 13:12 pick the slave port
  localparam int REGION_LSB = 12;
  // 16 KiB, first address outside the map
  localparam logic [ADDR_WIDTH-1:0] DECODE_LIMIT = 32'h0000_4000;

  typedef logic [PORT_IDX_WIDTH-1:0]  port_idx_t;
  typedef logic [ID_WIDTH-1:0]        axi_id_t;
  typedef logic [ADDR_WIDTH-1:0]      axi_addr_t;
  typedef logic [LEN_WIDTH-1:0]       axi_len_t;
  typedef logic [RESP_WIDTH-1:0]      axi_resp_t;
  typedef logic [ERR_COUNT_WIDTH-1:0] err_count_t;

  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } ax_beat_t;

  typedef struct packed {
    logic     valid;
    logic     ready;
    ax_beat_t beat;
  } ax_chan_t;

  // last is tied high on B channels
  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
    logic      last;
  } rsp_beat_t;

  typedef struct packed {
    logic      valid;
    logic      ready;
    rsp_beat_t beat;
  } rsp_chan_t;

  typedef enum logic [2:0] {
    ERR_NONE,
    ERR_DECODE,
    ERR_REQ_UNEXPECTED,
    ERR_REQ_MISMATCH,
    ERR_RSP_UNEXPECTED,
    ERR_RSP_MISMATCH,
    ERR_OVERFLOW
  } err_code_e;

  typedef enum logic {
    PATH_WRITE,
    PATH_READ
  } path_e;

  typedef struct packed {
    err_code_e code;
    path_e     path;
    port_idx_t port;
  } err_info_t;

endpackage
